/* hw/chan_buffer_defines.svh */
// ====================================================================
// Channel buffer configuration macros: channel count, bank depth,
// pointer and data widths, and the initial output credit count.
// ====================================================================
`ifndef CHAN_BUFFER_DEFINES_SVH
`define CHAN_BUFFER_DEFINES_SVH

// Number of sender channels, one bank each.
`define CB_NUM_CH 2

// Entries per bank, also the initial credits of each sender.
`define CB_CH_DEPTH 8

// Pointer bits within one bank.
`define CB_CH_AW 3

`define CB_DATA_W 16

`define CB_OUT_CREDITS 4 // Downstream credits after reset.

`endif

/* hw/cb_data_pkg.sv */
// ====================================================================
// Channel buffer data path types: input beats, bank writes and
// output beats.
// ====================================================================
`include "chan_buffer_defines.svh"

package cb_data_pkg;

  // Beat from a sender. Valid only while the sender holds a credit.
  typedef struct packed {
    logic                  valid;
    logic [`CB_DATA_W-1:0] data;
  } in_beat_t;

  // Write port of one bank.
  typedef struct packed {
    logic                  en;
    logic [`CB_CH_AW-1:0]  ptr;
    logic [`CB_DATA_W-1:0] data;
  } ram_wr_t;

  // Beat to the downstream side, tagged with its source channel.
  typedef struct packed {
    logic                  valid;
    logic                  ch;
    logic [`CB_DATA_W-1:0] data;
  } out_beat_t;

endpackage

/* hw/cb_arb_pkg.sv */
// ====================================================================
// Channel buffer arbitration types: channel select and the per-channel
// request and grant vector.
// ====================================================================
`include "chan_buffer_defines.svh"

package cb_arb_pkg;

  // Priority holder, also the read bank select.
  typedef enum logic {
    CH0 = 1'b0,
    CH1 = 1'b1
  } ch_sel_e;

  typedef logic [`CB_NUM_CH-1:0] ch_vec_t; // One bit per channel.

  // Round-robin partner of a channel.
  function automatic ch_sel_e other_ch(input ch_sel_e c);
    return (c == CH0) ? CH1 : CH0;
  endfunction

endpackage

/* hw/fifo_ctrl.sv */
// ====================================================================
// Per-channel FIFO control: bank pointers, occupancy, read request
// and sender credit return.
// ====================================================================
`timescale 1ns/1ps
`include "chan_buffer_defines.svh"

module fifo_ctrl #(
  parameter int CH_ID = 0
) (
  input  logic                  rclk,
  input  logic                  rrstn,
  input  cb_data_pkg::in_beat_t in_beat,
  input  logic                  rd_gnt,
  output cb_data_pkg::ram_wr_t  ram_wr,
  output logic                  rd_req,
  output logic [`CB_CH_AW-1:0]  raddr,
  output logic                  credit_ret
);

  logic [`CB_CH_AW-1:0] wptr;
  logic [`CB_CH_AW-1:0] rptr;
  logic [`CB_CH_AW:0]   occ; // 0 to CB_CH_DEPTH.

  // Beat goes straight into the bank at the accepting edge.
  always_comb begin
    ram_wr.en   = in_beat.valid;
    ram_wr.ptr  = wptr;
    ram_wr.data = in_beat.data;
  end

  assign rd_req = (occ != '0);
  assign raddr  = rptr;

  // Depth is a power of two, so the pointers wrap on overflow.
  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      wptr <= '0;
    end else if (in_beat.valid) begin
      wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      rptr <= '0;
    end else if (rd_gnt) begin
      rptr <= rptr + 1'b1;
    end
  end

  // Write and grant in one cycle leave the count unchanged.
  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      occ <= '0;
    end else begin
      case ({in_beat.valid, rd_gnt})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  // One credit back per slot read out.
  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      credit_ret <= 1'b0;
    end else begin
      credit_ret <= rd_gnt;
    end
  end

  // Sender wrote without a credit.
  a_no_write_when_full: assert property (
    @(posedge rclk) disable iff (!rrstn)
    in_beat.valid |-> (occ < `CB_CH_DEPTH)
  ) else $error("fifo_ctrl ch%0d: write into full bank", CH_ID);

  // Arbiter granted an idle channel.
  a_gnt_needs_req: assert property (
    @(posedge rclk) disable iff (!rrstn)
    rd_gnt |-> rd_req
  ) else $error("fifo_ctrl ch%0d: grant without request", CH_ID);

endmodule

/* hw/buffer_ram.sv */
// ====================================================================
// Banked buffer memory. One write port per channel bank, one shared
// read port with registered output.
// ====================================================================
`timescale 1ns/1ps
`include "chan_buffer_defines.svh"

module buffer_ram (
  input  logic                   rclk,
  input  cb_data_pkg::ram_wr_t   ram_wr0,
  input  cb_data_pkg::ram_wr_t   ram_wr1,
  input  logic                   rd_en,
  input  cb_arb_pkg::ch_sel_e    rd_sel,
  input  logic [`CB_CH_AW-1:0]   rd_addr,
  output logic [`CB_DATA_W-1:0]  rd_data
);

  logic [`CB_DATA_W-1:0] mem [`CB_NUM_CH][`CB_CH_DEPTH];
  cb_data_pkg::ram_wr_t  wr [`CB_NUM_CH];

  assign wr[0] = ram_wr0;
  assign wr[1] = ram_wr1;

  // Banks are disjoint, so both ports may write in the same cycle.
  always_ff @(posedge rclk) begin
    for (int b = 0; b < `CB_NUM_CH; b++) begin
      if (wr[b].en) begin
        mem[b][wr[b].ptr] <= wr[b].data;
      end
    end
  end

  always_ff @(posedge rclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_sel][rd_addr]; // Valid the cycle after rd_en.
    end
  end

endmodule

/* hw/rd_arbiter.sv */
// ====================================================================
// Round-robin read arbiter for the shared RAM read port, gated by the
// downstream credit count.
// ====================================================================
`timescale 1ns/1ps
`include "chan_buffer_defines.svh"

module rd_arbiter (
  input  logic                   rclk,
  input  logic                   rrstn,
  input  cb_arb_pkg::ch_vec_t    rd_req,
  input  logic [`CB_CH_AW-1:0]   raddr0,
  input  logic [`CB_CH_AW-1:0]   raddr1,
  input  logic [`CB_DATA_W-1:0]  rd_data,
  input  logic                   out_credit,
  output cb_arb_pkg::ch_vec_t    rd_gnt,
  output logic                   rd_en,
  output cb_arb_pkg::ch_sel_e    rd_sel,
  output logic [`CB_CH_AW-1:0]   rd_addr,
  output cb_data_pkg::out_beat_t out_beat
);

  localparam int CRED_W = $clog2(`CB_OUT_CREDITS + 1);

  logic [CRED_W-1:0]   cred;
  cb_arb_pkg::ch_sel_e prio;
  cb_arb_pkg::ch_sel_e gnt_ch;
  logic                valid_q;
  logic                ch_q;

  // Priority channel first, the other only when priority is idle.
  always_comb begin
    rd_gnt = '0;
    gnt_ch = prio;
    if (cred != '0) begin
      if (rd_req[prio]) begin
        rd_gnt[prio] = 1'b1;
      end else if (rd_req[cb_arb_pkg::other_ch(prio)]) begin
        gnt_ch = cb_arb_pkg::other_ch(prio);
        rd_gnt[gnt_ch] = 1'b1;
      end
    end
  end

  assign rd_en   = |rd_gnt;
  assign rd_sel  = gnt_ch;
  assign rd_addr = (gnt_ch == cb_arb_pkg::CH1) ? raddr1 : raddr0;

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      prio <= cb_arb_pkg::CH0;
    end else if (rd_en) begin
      prio <= cb_arb_pkg::other_ch(gnt_ch); // Hand priority over.
    end
  end

  // Grant spends a credit, out_credit returns one.
  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      cred <= CRED_W'(`CB_OUT_CREDITS);
    end else begin
      case ({rd_en, out_credit})
        2'b10:   cred <= cred - 1'b1;
        2'b01:   cred <= cred + 1'b1;
        default: cred <= cred;
      endcase
    end
  end

  // Lines up with the registered RAM data.
  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      valid_q <= 1'b0;
      ch_q    <= 1'b0;
    end else begin
      valid_q <= rd_en;
      ch_q    <= gnt_ch;
    end
  end

  assign out_beat = '{valid: valid_q, ch: ch_q, data: rd_data};

  // Downstream returned more than it was given.
  a_cred_bound: assert property (
    @(posedge rclk) disable iff (!rrstn)
    cred <= `CB_OUT_CREDITS
  ) else $error("rd_arbiter: output credit overflow");

endmodule

/* hw/chan_buffer_top.sv */
// ====================================================================
// Two-channel credit-controlled packet buffer. Two FIFO controllers
// share one banked RAM through a round-robin read arbiter.
// ====================================================================
`timescale 1ns/1ps
`include "chan_buffer_defines.svh"

module chan_buffer_top (
  input  logic                   rclk,
  input  logic                   rrstn,
  input  cb_data_pkg::in_beat_t  in_beat0,
  input  cb_data_pkg::in_beat_t  in_beat1,
  output cb_arb_pkg::ch_vec_t    credit_ret,
  input  logic                   out_credit,
  output cb_data_pkg::out_beat_t out_beat
);

  cb_data_pkg::ram_wr_t  ram_wr0;
  cb_data_pkg::ram_wr_t  ram_wr1;
  cb_arb_pkg::ch_vec_t   rd_req;
  cb_arb_pkg::ch_vec_t   rd_gnt;
  logic [`CB_CH_AW-1:0]  raddr0;
  logic [`CB_CH_AW-1:0]  raddr1;
  logic                  rd_en;
  cb_arb_pkg::ch_sel_e   rd_sel;
  logic [`CB_CH_AW-1:0]  rd_addr;
  logic [`CB_DATA_W-1:0] rd_data;

  fifo_ctrl #(.CH_ID(0)) i_fifo_ctrl0 (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .in_beat    (in_beat0),
    .rd_gnt     (rd_gnt[0]),
    .ram_wr     (ram_wr0),
    .rd_req     (rd_req[0]),
    .raddr      (raddr0),
    .credit_ret (credit_ret[0])
  );

  fifo_ctrl #(.CH_ID(1)) i_fifo_ctrl1 (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .in_beat    (in_beat1),
    .rd_gnt     (rd_gnt[1]),
    .ram_wr     (ram_wr1),
    .rd_req     (rd_req[1]),
    .raddr      (raddr1),
    .credit_ret (credit_ret[1])
  );

  buffer_ram i_buffer_ram (
    .rclk    (rclk),
    .ram_wr0 (ram_wr0),
    .ram_wr1 (ram_wr1),
    .rd_en   (rd_en),
    .rd_sel  (rd_sel),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  rd_arbiter i_rd_arbiter (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .rd_req     (rd_req),
    .raddr0     (raddr0),
    .raddr1     (raddr1),
    .rd_data    (rd_data),
    .out_credit (out_credit),
    .rd_gnt     (rd_gnt),
    .rd_en      (rd_en),
    .rd_sel     (rd_sel),
    .rd_addr    (rd_addr),
    .out_beat   (out_beat)
  );

endmodule

/* sim/tb_chan_buffer.sv */
// ======================================================================
// Testbench for the two-channel packet buffer: credit-obeying senders,
// downstream credit return, reference queues and output checks.
// ======================================================================
`timescale 1ns/1ps
`include "chan_buffer_defines.svh"

module tb_chan_buffer;

  localparam int CM_CONT   = 0;
  localparam int CM_RANDOM = 1;
  localparam int CM_HOLD   = 2;
  localparam int WAIT_MAX  = 2000; // Cycles per wait loop.

  logic                   rclk = 1'b0;
  logic                   rrstn;
  cb_data_pkg::in_beat_t  in_beat0;
  cb_data_pkg::in_beat_t  in_beat1;
  cb_arb_pkg::ch_vec_t    credit_ret;
  logic                   out_credit;
  cb_data_pkg::out_beat_t out_beat;

  integer seed   = 46399;
  int     errors = 0;
  bit     run_ok = 1'b1;

  // Words sent and not yet seen at the output.
  logic [`CB_DATA_W-1:0] model_q0 [$];
  logic [`CB_DATA_W-1:0] model_q1 [$];
  logic [`CB_DATA_W-1:0] exp_word;

  int snd_cred [`CB_NUM_CH];
  int sent_cnt [`CB_NUM_CH];
  int ret_cnt  [`CB_NUM_CH];
  bit send_en  [`CB_NUM_CH];
  int send_rate;     // Out of 8.
  int credit_mode;
  int owed;          // Outputs seen, credit not yet returned.
  int pause_left;
  int credit_given;
  int out_total;
  bit fair_en;
  bit have_prev;
  bit prev_ch;
  bit other_pending;

  chan_buffer_top i_dut (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .in_beat0   (in_beat0),
    .in_beat1   (in_beat1),
    .credit_ret (credit_ret),
    .out_credit (out_credit),
    .out_beat   (out_beat)
  );

  always #50 rclk = ~rclk;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t: %s, got %0h expected %0h", $time, what, actual, expected);
    end
  endtask

  // Oldest unread word of the given channel.
  function automatic logic [`CB_DATA_W-1:0] expected_word(input logic ch);
    logic [`CB_DATA_W-1:0] w;
    w = 'x;
    if (ch == 1'b0) begin
      if (model_q0.size() > 0) begin
        w = model_q0.pop_front();
      end
    end else begin
      if (model_q1.size() > 0) begin
        w = model_q1.pop_front();
      end
    end
    return w;
  endfunction

  task automatic step_sender(input int ch);
    logic [31:0]           r;
    logic [31:0]           r2;
    logic [`CB_DATA_W-1:0] word;
    bit                    go;
    r    = $random(seed);
    r2   = $random(seed);
    word = r2[`CB_DATA_W-1:0];
    if (credit_ret[ch]) begin
      snd_cred[ch]++;
      ret_cnt[ch]++;
      check_value(snd_cred[ch] <= `CB_CH_DEPTH, 1, "sender credit above bank depth");
    end
    go = send_en[ch] && (snd_cred[ch] > 0) && (r[2:0] < send_rate);
    if (go) begin
      snd_cred[ch]--;
      sent_cnt[ch]++;
    end
    if (ch == 0) begin
      in_beat0.valid = go;
      in_beat0.data  = go ? word : '0;
      if (go) begin
        model_q0.push_back(word);
      end
    end else begin
      in_beat1.valid = go;
      in_beat1.data  = go ? word : '0;
      if (go) begin
        model_q1.push_back(word);
      end
    end
  endtask

  // One returned credit per output beat, paused as the mode says.
  task automatic step_downstream();
    logic [31:0] r;
    r = $random(seed);
    if (rrstn && out_beat.valid) begin
      owed++;
    end
    if (credit_mode == CM_RANDOM && pause_left == 0 && r[7:4] == 4'h0) begin
      pause_left = 4 + r[11:8];
    end
    out_credit = 1'b0;
    if (pause_left > 0) begin
      pause_left--;
    end else if (credit_mode != CM_HOLD && owed > 0 &&
                 (credit_mode == CM_CONT || r[1:0] != 2'b00)) begin
      out_credit = 1'b1;
      owed--;
    end
  endtask

  // All inputs change on the falling edge.
  always @(negedge rclk) begin
    step_sender(0);
    step_sender(1);
    step_downstream();
  end

  always @(posedge rclk) begin
    if (rrstn && out_credit) begin
      credit_given++;
    end
  end

  // Output checker.
  always @(negedge rclk) begin
    if (rrstn && out_beat.valid) begin
      exp_word = expected_word(out_beat.ch);
      check_value(out_beat.data, exp_word, "output word");
      out_total++;
      check_value(out_total <= `CB_OUT_CREDITS + credit_given, 1, "output beyond credit");
      if (fair_en && have_prev && other_pending) begin
        check_value(out_beat.ch, !prev_ch, "round-robin order");
      end
      prev_ch       = out_beat.ch;
      have_prev     = 1'b1;
      other_pending = out_beat.ch ? (model_q0.size() > 0) : (model_q1.size() > 0);
    end
  end

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (run_ok && !(model_q0.size() == 0 && model_q1.size() == 0 && owed == 0 &&
                       snd_cred[0] == `CB_CH_DEPTH && snd_cred[1] == `CB_CH_DEPTH)) begin
      @(posedge rclk);
      n++;
      if (n >= WAIT_MAX) begin
        $display("ERROR t=%0t: buffer did not drain after %s", $time, what);
        errors++;
        run_ok = 1'b0;
      end
    end
  endtask

  task automatic wait_sender_empty(input int ch);
    int n;
    n = 0;
    while (run_ok && snd_cred[ch] != 0) begin
      @(posedge rclk);
      n++;
      if (n >= WAIT_MAX) begin
        $display("ERROR t=%0t: sender %0d never ran out of credit", $time, ch);
        errors++;
        run_ok = 1'b0;
      end
    end
  endtask

  initial begin
    int base;
    rrstn       = 1'b0;
    in_beat0    = '0;
    in_beat1    = '0;
    out_credit  = 1'b0;
    credit_mode = CM_CONT;
    send_rate   = 0;
    snd_cred[0] = `CB_CH_DEPTH;
    snd_cred[1] = `CB_CH_DEPTH;
    repeat (3) @(posedge rclk);
    @(negedge rclk);
    rrstn = 1'b1;

    // Nothing comes out before input.
    repeat (10) begin
      @(negedge rclk);
      check_value(out_beat.valid, 0, "out_beat.valid while idle");
      check_value(credit_ret, 0, "credit_ret while idle");
    end

    // Random traffic on both channels with paused credit returns.
    @(posedge rclk);
    credit_mode = CM_RANDOM;
    send_rate   = 5;
    send_en[0]  = 1'b1;
    send_en[1]  = 1'b1;
    repeat (400) @(posedge rclk);
    send_en[0]  = 1'b0;
    send_en[1]  = 1'b0;
    credit_mode = CM_CONT;
    wait_drain("random traffic");

    // Output back-pressure.
    credit_mode = CM_HOLD;
    send_rate   = 8;
    send_en[0]  = 1'b1;
    send_en[1]  = 1'b1;
    repeat (6) @(posedge rclk);
    send_en[0]  = 1'b0;
    send_en[1]  = 1'b0;
    repeat (30) @(posedge rclk);
    check_value(out_total, `CB_OUT_CREDITS + credit_given, "outputs under held credits");
    base = out_total;
    repeat (10) @(posedge rclk);
    check_value(out_total, base, "output count while out of credit");
    credit_mode = CM_CONT;
    wait_drain("back-pressure release");

    // Fill bank 0, then bank 1, release and expect alternation.
    credit_mode = CM_HOLD;
    send_en[0]  = 1'b1;
    wait_sender_empty(0);
    repeat (10) begin
      @(posedge rclk);
      check_value(in_beat0.valid, 0, "sender 0 stalled on full bank");
      check_value(snd_cred[0], 0, "sender 0 credit on full bank");
    end
    check_value(model_q0.size(), `CB_CH_DEPTH, "words held in bank 0");
    send_en[1] = 1'b1;
    wait_sender_empty(1);
    send_en[0]  = 1'b0;
    send_en[1]  = 1'b0;
    fair_en     = 1'b1;
    credit_mode = CM_CONT;
    wait_drain("full bank release");
    fair_en = 1'b0;

    check_value(snd_cred[0], `CB_CH_DEPTH, "final sender 0 credit");
    check_value(snd_cred[1], `CB_CH_DEPTH, "final sender 1 credit");
    check_value(ret_cnt[0], sent_cnt[0], "credit returns on channel 0");
    check_value(ret_cnt[1], sent_cnt[1], "credit returns on channel 1");

    $display("Done: errors=%0d sent=%0d/%0d received=%0d", errors, sent_cnt[0],
             sent_cnt[1], out_total);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* chan_buffer.f */
+incdir+hw
hw/cb_data_pkg.sv
hw/cb_arb_pkg.sv
hw/fifo_ctrl.sv
hw/buffer_ram.sv
hw/rd_arbiter.sv
hw/chan_buffer_top.sv
sim/tb_chan_buffer.sv
